//--- include/branch_params.svh
// sizing and encoding macros for the branch prediction slice
// include wherever table, queue or stack depths or branch codes are needed
`ifndef BRANCH_PARAMS_SVH
`define BRANCH_PARAMS_SVH

// direct-mapped predictor table
`define BHT_ENTRIES       16
`define BHT_INDEX_BITS    4

// in-flight predictions between fetch and execute, also the fetch credit pool
`define PRED_QUEUE_DEPTH  4

// speculative return-address stack
`define RAS_DEPTH         4

// branch codes carried in branchType_t.branchCode
`define BRANCH_CODE_BEQ   3'd0
`define BRANCH_CODE_BNE   3'd1
`define BRANCH_CODE_BGE   3'd2
`define BRANCH_CODE_BGT   3'd3
`define BRANCH_CODE_BLE   3'd4
`define BRANCH_CODE_BLT   3'd5
`define BRANCH_CODE_J     3'd6
`define BRANCH_CODE_JR    3'd7

`endif

//--- design/decodePkg.sv
// types describing the instruction that execute hands to the resolver
// referenced with decodePkg:: scoped names

package decodePkg;

    // branch class as produced by decode
    typedef struct packed {
        logic       isBranch;
        logic [2:0] branchCode;   // one of the BRANCH_CODE_* values
    } branchType_t;

    // operands and addresses for the instruction being resolved (133 bits)
    typedef struct packed {
        branchType_t kind;
        logic        isCall;      // J/JR that links
        logic [31:0] opA;         // rs value, also JR target
        logic [31:0] opB;         // rt value
        logic [31:0] jumpAddr;    // J target
        logic [31:0] branchAddr;  // taken conditional target
    } exeBranch_t;

endpackage

//--- design/predictPkg.sv
// types for fetch requests, prediction records and predictor updates
// referenced with predictPkg:: scoped names

package predictPkg;

    // what kind of control transfer a table entry describes
    typedef enum logic [1:0] {
        none = 2'd0,
        imme = 2'd1,
        call = 2'd2,
        retn = 2'd3
    } bKind_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } fetchReq_t;

    // one prediction, travels with the instruction until execute
    typedef struct packed {
        logic        valid;
        logic        hit;
        logic [1:0]  count;   // counter snapshot at lookup
        bKind_t      kind;
        logic [31:0] pc;
        logic [31:0] target;  // predicted next pc
    } pResult_t;

    // resolved outcome sent back to train the table
    typedef struct packed {
        logic        valid;
        logic        hit;
        logic [1:0]  count;
        bKind_t      kind;
        logic        isTaken;
        logic [31:0] pc;
        logic [31:0] target;
        logic        retnSuccess;
    } bResult_t;

endpackage

//--- design/creditFifo.sv
// in-order queue for any packed payload, with flush and freed-slot counting
// freed feeds the fetch credit return; FALLTHROUGH lets an empty queue
// present the incoming entry at its head in the same cycle
`timescale 1ns/1ps
`include "branch_params.svh"

module creditFifo #(
    parameter type payload_t   = logic [31:0],
    parameter int  DEPTH       = `PRED_QUEUE_DEPTH,
    parameter bit  FALLTHROUGH = 1'b0
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     push,
    input  payload_t pushData,
    input  logic     pop,
    input  logic     flush,
    output logic     headValid,
    output payload_t headData,
    output logic [2:0] freed
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t            mem [DEPTH];
    logic [PTR_BITS-1:0] rdPtr, wrPtr;
    logic [CNT_BITS-1:0] count;
    logic                empty, doPush, doPop, bypass, storeIn;

    assign empty   = (count == '0);
    assign doPush  = push && (count < CNT_BITS'(DEPTH));
    assign bypass  = FALLTHROUGH && empty && push && pop;  // consumed without storing
    assign storeIn = doPush && !bypass;
    assign doPop   = pop && !empty;

    assign headValid = !empty || (FALLTHROUGH && push);
    assign headData  = (FALLTHROUGH && empty) ? pushData : mem[rdPtr];

    // flush gives back everything held plus the push it refuses
    assign freed = flush ? (3'(count) + 3'(push)) : 3'(pop && headValid);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else if (flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (storeIn)
                wrPtr <= (wrPtr == PTR_BITS'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (doPop)
                rdPtr <= (rdPtr == PTR_BITS'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            count <= count + CNT_BITS'(storeIn) - CNT_BITS'(doPop);
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        if (storeIn && !flush)
            mem[wrPtr] <= pushData;
    end

endmodule

//--- design/branchPredictor.sv
// direct-mapped branch predictor with 2-bit counters and a return stack
// lookup is combinational on fetchReq, predResp is the registered copy;
// training comes from resolved update records
`timescale 1ns/1ps
`include "branch_params.svh"

module branchPredictor (
    input  logic                  clk,
    input  logic                  rstN,
    input  predictPkg::fetchReq_t fetchReq,
    input  logic                  discard,
    input  predictPkg::bResult_t  update,
    output predictPkg::pResult_t  lookup,    // same-cycle record for the queue
    output predictPkg::pResult_t  predResp
);

    localparam int TAG_BITS = 32 - 2 - `BHT_INDEX_BITS;
    localparam int RAS_BITS = $clog2(`RAS_DEPTH);

    logic                      entryValid [`BHT_ENTRIES];
    logic [TAG_BITS-1:0]       entryTag   [`BHT_ENTRIES];
    logic [31:0]               entryTgt   [`BHT_ENTRIES];
    predictPkg::bKind_t        entryKind  [`BHT_ENTRIES];
    logic [1:0]                entryCnt   [`BHT_ENTRIES];

    logic [31:0]               ras [`RAS_DEPTH];
    logic [RAS_BITS-1:0]       rasPtr;
    logic [RAS_BITS:0]         rasCount;
    logic [31:0]               rasTop;

    logic [`BHT_INDEX_BITS-1:0] rdIdx, wrIdx;
    logic                       hit, live;
    logic [31:0]                pcAdd8;
    logic [1:0]                 newCnt;

    assign rdIdx  = fetchReq.pc[`BHT_INDEX_BITS+1:2];
    assign hit    = entryValid[rdIdx] && (entryTag[rdIdx] == fetchReq.pc[31:32-TAG_BITS]);
    assign pcAdd8 = fetchReq.pc + 32'd8;
    assign rasTop = ras[rasPtr - 1'b1];
    assign live   = fetchReq.valid && !discard;

    always_comb begin
        lookup.valid  = fetchReq.valid;
        lookup.hit    = hit;
        lookup.count  = hit ? entryCnt[rdIdx] : 2'd0;
        lookup.kind   = hit ? entryKind[rdIdx] : predictPkg::none;
        lookup.pc     = fetchReq.pc;
        if (hit && entryKind[rdIdx] == predictPkg::retn && rasCount != '0)
            lookup.target = rasTop;             // return predicted from stack
        else if (hit && entryCnt[rdIdx] >= 2'd2)
            lookup.target = entryTgt[rdIdx];
        else
            lookup.target = pcAdd8;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            predResp <= '0;
        end else begin
            predResp       <= lookup;
            predResp.valid <= live;     // wrong-path lookup dropped
        end
    end

    // speculative return stack, wraps when full
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rasPtr   <= '0;
            rasCount <= '0;
        end else if (live && hit && entryKind[rdIdx] == predictPkg::call) begin
            rasPtr <= rasPtr + 1'b1;
            if (rasCount != (RAS_BITS+1)'(`RAS_DEPTH))
                rasCount <= rasCount + 1'b1;
        end else if (live && hit && entryKind[rdIdx] == predictPkg::retn && rasCount != '0) begin
            rasPtr   <= rasPtr - 1'b1;
            rasCount <= rasCount - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (live && hit && entryKind[rdIdx] == predictPkg::call)
            ras[rasPtr] <= pcAdd8;
    end

    // training
    assign wrIdx = update.pc[`BHT_INDEX_BITS+1:2];

    always_comb begin
        if (!update.hit)
            newCnt = update.isTaken ? 2'd2 : 2'd1;      // fresh entry
        else if (update.isTaken)
            newCnt = (update.count == 2'd3) ? 2'd3 : update.count + 2'd1;
        else
            newCnt = (update.count == 2'd0) ? 2'd0 : update.count - 2'd1;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `BHT_ENTRIES; i++)
                entryValid[i] <= 1'b0;
        end else if (update.valid && update.kind != predictPkg::none) begin
            entryValid[wrIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update.valid && update.kind != predictPkg::none) begin
            entryTag[wrIdx]  <= update.pc[31:32-TAG_BITS];
            entryTgt[wrIdx]  <= update.target;
            entryKind[wrIdx] <= update.kind;
            entryCnt[wrIdx]  <= newCnt;
        end
    end

endmodule

//--- design/branchSolve.sv
// branch resolver in execute: real direction, target and kind of the head
// instruction, checked against its prediction; raises the flush request
// and registers the redirect and the update record
`timescale 1ns/1ps
`include "branch_params.svh"

module branchSolve (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   exeValid,
    input  decodePkg::exeBranch_t  exeIn,
    input  predictPkg::pResult_t   head,
    output logic                   mispredict,
    output logic                   redirect,
    output logic [31:0]            correctionVector,
    output predictPkg::bResult_t   bResult
);

    logic               isTaken;
    logic [31:0]        realTarget;
    logic [31:0]        pcAdd8;
    predictPkg::bKind_t realKind;
    predictPkg::bResult_t nextResult;

    assign pcAdd8 = head.pc + 32'd8;

    // direction
    always_comb begin
        if (!exeIn.kind.isBranch) begin
            isTaken = 1'b0;
        end else begin
            case (exeIn.kind.branchCode)
                `BRANCH_CODE_BEQ: isTaken = (exeIn.opA == exeIn.opB);
                `BRANCH_CODE_BNE: isTaken = (exeIn.opA != exeIn.opB);
                `BRANCH_CODE_BGE: isTaken = ($signed(exeIn.opA) >= 0);
                `BRANCH_CODE_BGT: isTaken = ($signed(exeIn.opA) > 0);
                `BRANCH_CODE_BLE: isTaken = ($signed(exeIn.opA) <= 0);
                `BRANCH_CODE_BLT: isTaken = ($signed(exeIn.opA) < 0);
                default:          isTaken = 1'b1;       // J, JR
            endcase
        end
    end

    // target and kind
    always_comb begin
        realKind   = predictPkg::none;
        realTarget = pcAdd8;
        if (exeIn.kind.isBranch) begin
            case (exeIn.kind.branchCode)
                `BRANCH_CODE_J: begin
                    realKind   = exeIn.isCall ? predictPkg::call : predictPkg::imme;
                    realTarget = exeIn.jumpAddr;
                end
                `BRANCH_CODE_JR: begin
                    realKind   = exeIn.isCall ? predictPkg::call : predictPkg::retn;
                    realTarget = exeIn.opA;
                end
                default: begin
                    realKind = predictPkg::imme;
                    if (isTaken)
                        realTarget = exeIn.branchAddr;
                end
            endcase
        end
    end

    assign mispredict = exeValid && head.valid && (head.target != realTarget);

    always_comb begin
        nextResult.valid       = exeValid && head.valid;
        nextResult.hit         = head.hit;
        nextResult.count       = head.count;
        nextResult.kind        = realKind;
        nextResult.isTaken     = isTaken;
        nextResult.pc          = head.pc;
        nextResult.target      = realTarget;
        nextResult.retnSuccess = exeValid && !mispredict && head.kind == predictPkg::retn;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            redirect <= 1'b0;
            bResult  <= '0;
        end else begin
            redirect <= mispredict;
            bResult  <= nextResult;
        end
    end

    always_ff @(posedge clk) begin
        correctionVector <= realTarget;    // only meaningful with redirect
    end

endmodule

//--- design/branchUnit.sv
// top of the branch slice: predictor, prediction queue, resolver and the
// update buffer that carries resolved outcomes back for training
`timescale 1ns/1ps

module branchUnit (
    input  logic                  clk,
    input  logic                  rstN,
    input  predictPkg::fetchReq_t fetchReq,
    output logic [2:0]            creditReturn,
    output predictPkg::pResult_t  predResp,
    output logic                  headValid,
    input  logic                  exeValid,
    input  decodePkg::exeBranch_t exeIn,
    output logic                  redirect,
    output logic [31:0]           correctionVector
);

    predictPkg::pResult_t lookup;
    predictPkg::pResult_t head;
    predictPkg::bResult_t bResult;
    predictPkg::bResult_t update;
    logic                 mispredict;
    logic                 updHeadValid;

    branchPredictor u_branchPredictor (
        .clk(clk), .rstN(rstN),
        .fetchReq(fetchReq), .discard(mispredict), .update(update),
        .lookup(lookup), .predResp(predResp)
    );

    // prediction queue, its freed count is the credit return
    creditFifo #(.payload_t(predictPkg::pResult_t)) u_predQueue (
        .clk(clk), .rstN(rstN),
        .push(lookup.valid), .pushData(lookup), .pop(exeValid), .flush(mispredict),
        .headValid(headValid), .headData(head), .freed(creditReturn)
    );

    branchSolve u_branchSolve (
        .clk(clk), .rstN(rstN),
        .exeValid(exeValid), .exeIn(exeIn), .head(head),
        .mispredict(mispredict), .redirect(redirect),
        .correctionVector(correctionVector), .bResult(bResult)
    );

    // drained every cycle by the predictor
    creditFifo #(.payload_t(predictPkg::bResult_t), .DEPTH(2), .FALLTHROUGH(1'b1)) u_updBuf (
        .clk(clk), .rstN(rstN),
        .push(bResult.valid), .pushData(bResult), .pop(updHeadValid), .flush(1'b0),
        .headValid(updHeadValid), .headData(update), .freed()
    );

endmodule

//--- bench/branchUnit_checker.sv
// concurrent checks bound into branchUnit
// fetch credits, execute handshake, update buffer room and quiet reset outputs
`timescale 1ns/1ps
`include "branch_params.svh"

module branchUnit_checker (
    input logic                  clk,
    input logic                  rstN,
    input predictPkg::fetchReq_t fetchReq,
    input logic [2:0]            creditReturn,
    input predictPkg::pResult_t  predResp,
    input logic                  headValid,
    input logic                  exeValid,
    input logic                  redirect,
    input logic                  updPush,
    input logic [1:0]            updCount
);

    logic [3:0] credits;   // fetch side credit pool

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            credits <= 4'(`PRED_QUEUE_DEPTH);
        end else begin
            credits <= credits - 4'(fetchReq.valid) + 4'(creditReturn);
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) fetchReq.valid |-> credits != 4'd0)
        else $error("fetch request sent without a credit");

    assert property (@(posedge clk) disable iff (!rstN) exeValid |-> headValid)
        else $error("exeValid raised while the queue head is empty");

    // occupancy held by the update buffer itself
    assert property (@(posedge clk) disable iff (!rstN) updPush |-> updCount < 2'd2)
        else $error("update buffer overflow");

    // first edge out of reset
    assert property (@(posedge clk) $rose(rstN) |->
                     !redirect && !headValid && !predResp.valid && creditReturn == 3'd0)
        else $error("outputs not quiet after reset");

endmodule

bind branchUnit branchUnit_checker u_checker (
    .clk(clk), .rstN(rstN), .fetchReq(fetchReq), .creditReturn(creditReturn),
    .predResp(predResp), .headValid(headValid), .exeValid(exeValid), .redirect(redirect),
    .updPush(bResult.valid), .updCount(u_updBuf.count)
);

//--- bench/branchUnitTb.sv
// random regression for the branch slice
// xorshift stimulus from a fixed seed drives fetch and execute; a cycle model of
// the table, return stack, prediction queue and credits is checked every cycle
`timescale 1ns/1ps
`include "branch_params.svh"

module branchUnitTb;

    localparam int NUM_TXN = 3000;   // one fetch/execute slot per cycle
    localparam int DRAIN   = 16;

    logic                  clk;
    logic                  rstN;
    predictPkg::fetchReq_t fetchReq;
    logic [2:0]            creditReturn;
    predictPkg::pResult_t  predResp;
    logic                  headValid;
    logic                  exeValid;
    decodePkg::exeBranch_t exeIn;
    logic                  redirect;
    logic [31:0]           correctionVector;

    branchUnit u_branchUnit (.*);

    logic [31:0]           rngState = 32'd86;
    decodePkg::exeBranch_t prog [8];        // base instruction at each pool pc
    logic                  mValid [`BHT_ENTRIES];
    logic [25:0]           mTag   [`BHT_ENTRIES];
    logic [31:0]           mTgt   [`BHT_ENTRIES];
    predictPkg::bKind_t    mKind  [`BHT_ENTRIES];
    logic [1:0]            mCnt   [`BHT_ENTRIES];
    logic [31:0]           mRas   [`RAS_DEPTH];
    logic [1:0]            mRasPtr;
    int                    mRasCnt;
    predictPkg::pResult_t  predQ [$];
    logic [2:0]            idxQ [$];
    predictPkg::bResult_t  pendUpd;         // trains the table at the next edge
    predictPkg::pResult_t  expPred;
    logic                  expRedirect;
    logic [31:0]           expVector;
    int                    credits;
    logic [31:0]           lastLink;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // 8 pcs, pairs share a table index so entries alias
    function automatic logic [31:0] poolPc(logic [2:0] k);
        return 32'h400 + 32'(k[1:0]) * 32'd4 + 32'(k[2]) * 32'h40;
    endfunction

    function automatic logic [31:0] pickOperand();
        case (nextRand() % 4)
            0:       return 32'd0;
            1:       return 32'hFFFF_FFFF;
            2:       return 32'd1;
            default: return nextRand();
        endcase
    endfunction

    function automatic predictPkg::pResult_t modelLookup(logic [31:0] pc);
        predictPkg::pResult_t r;
        logic [3:0]           i;
        i       = pc[5:2];
        r.valid = 1'b1;
        r.hit   = mValid[i] && (mTag[i] == pc[31:6]);
        r.count = r.hit ? mCnt[i] : 2'd0;
        r.kind  = r.hit ? mKind[i] : predictPkg::none;
        r.pc    = pc;
        if (r.hit && r.kind == predictPkg::retn && mRasCnt != 0)
            r.target = mRas[mRasPtr - 1'b1];
        else if (r.hit && r.count >= 2'd2)
            r.target = mTgt[i];
        else
            r.target = pc + 32'd8;
        return r;
    endfunction

    function automatic predictPkg::bResult_t modelResolve(decodePkg::exeBranch_t e,
                                                          predictPkg::pResult_t h);
        predictPkg::bResult_t r;
        logic [2:0]           code;
        code     = e.kind.branchCode;
        r        = '0;
        r.valid  = 1'b1;
        r.hit    = h.hit;
        r.count  = h.count;
        r.pc     = h.pc;
        r.kind   = predictPkg::none;
        r.target = h.pc + 32'd8;
        if (e.kind.isBranch) begin
            case (code)
                `BRANCH_CODE_BEQ: r.isTaken = (e.opA == e.opB);
                `BRANCH_CODE_BNE: r.isTaken = (e.opA != e.opB);
                `BRANCH_CODE_BGE: r.isTaken = !e.opA[31];
                `BRANCH_CODE_BGT: r.isTaken = !e.opA[31] && (e.opA != 32'd0);
                `BRANCH_CODE_BLE: r.isTaken = e.opA[31] || (e.opA == 32'd0);
                `BRANCH_CODE_BLT: r.isTaken = e.opA[31];
                default:          r.isTaken = 1'b1;
            endcase
            if (code == `BRANCH_CODE_J) begin
                r.target = e.jumpAddr;
                r.kind   = e.isCall ? predictPkg::call : predictPkg::imme;
            end else if (code == `BRANCH_CODE_JR) begin
                r.target = e.opA;
                r.kind   = e.isCall ? predictPkg::call : predictPkg::retn;
            end else begin
                r.kind = predictPkg::imme;
                if (r.isTaken)
                    r.target = e.branchAddr;
            end
        end
        r.retnSuccess = (h.kind == predictPkg::retn) && (h.target == r.target);
        return r;
    endfunction

    task automatic trainModel(predictPkg::bResult_t u);
        logic [3:0] i;
        i = u.pc[5:2];
        if (u.valid && u.kind != predictPkg::none) begin
            mValid[i] = 1'b1;
            mTag[i]   = u.pc[31:6];
            mTgt[i]   = u.target;
            mKind[i]  = u.kind;
            if (!u.hit)
                mCnt[i] = u.isTaken ? 2'd2 : 2'd1;   // new entry
            else if (u.isTaken)
                mCnt[i] = (u.count == 2'd3) ? 2'd3 : u.count + 2'd1;
            else
                mCnt[i] = (u.count == 2'd0) ? 2'd0 : u.count - 2'd1;
        end
    endtask

    task automatic stopOnError(string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic comparePred(predictPkg::pResult_t exp);
        if (predResp.valid !== exp.valid || (exp.valid && predResp !== exp))
            stopOnError($sformatf("FAIL t=%0t predResp got=%h exp=%h", $time, predResp, exp));
    endtask

    task automatic compareRedirect(logic valid, logic [31:0] vector);
        if (redirect !== valid)
            stopOnError($sformatf("FAIL t=%0t redirect got=%b exp=%b", $time, redirect, valid));
        else if (valid && correctionVector !== vector)
            stopOnError($sformatf("FAIL t=%0t correctionVector got=%h exp=%h",
                                  $time, correctionVector, vector));
    endtask

    task automatic compareCredit(logic [2:0] exp);
        if (creditReturn !== exp)
            stopOnError($sformatf("FAIL t=%0t creditReturn got=%0d exp=%0d",
                                  $time, creditReturn, exp));
    endtask

    task automatic compareHead(logic exp);
        if (headValid !== exp)
            stopOnError($sformatf("FAIL t=%0t headValid got=%b exp=%b", $time, headValid, exp));
    endtask

    initial begin
        #(NUM_TXN * 10 * 4);
        stopOnError("timeout: the run did not finish in the expected time");
    end

    initial begin
        logic                  doFetch;
        logic                  doExe;
        logic                  mis;
        logic [2:0]            fetchIdx;
        logic [2:0]            expCredit;
        int                    rot;
        predictPkg::pResult_t  look;
        predictPkg::bResult_t  res;
        decodePkg::exeBranch_t e;

        rstN     = 1'b0;
        fetchReq = '0;
        exeValid = 1'b0;
        exeIn    = '0;
        rot      = nextRand() % 6;   // conditional codes spread over pcs 0 to 5
        for (int k = 0; k < 8; k++) begin
            prog[k]                 = '0;
            prog[k].kind.isBranch   = 1'b1;
            prog[k].kind.branchCode = 3'((k + rot) % 6);
            prog[k].jumpAddr   = poolPc(3'(nextRand() % 8));
            prog[k].branchAddr = poolPc(3'(nextRand() % 8));
        end
        prog[6].kind       = '{isBranch: 1'b1, branchCode: `BRANCH_CODE_J};   // call
        prog[6].isCall     = 1'b1;
        prog[7].kind       = '{isBranch: 1'b1, branchCode: `BRANCH_CODE_JR};  // return
        prog[7].isCall     = 1'b0;
        for (int k = 0; k < `BHT_ENTRIES; k++)
            mValid[k] = 1'b0;
        mRasPtr     = '0;
        mRasCnt     = 0;
        pendUpd     = '0;
        expPred     = '0;
        expRedirect = 1'b0;
        expVector   = '0;
        credits     = `PRED_QUEUE_DEPTH;
        lastLink    = poolPc(3'd6) + 32'd8;
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;

        for (int cyc = 0; cyc < NUM_TXN + DRAIN; cyc++) begin
            @(posedge clk);
            #1;
            comparePred(expPred);
            compareRedirect(expRedirect, expVector);
            compareHead(predQ.size() != 0);
            doFetch  = cyc < NUM_TXN && credits > 0 && (nextRand() % 4) != 0;
            doExe    = predQ.size() != 0 && (cyc >= NUM_TXN || (nextRand() % 3) != 0);
            fetchIdx = 3'(nextRand() % 8);
            fetchReq.valid = doFetch;
            fetchReq.pc    = poolPc(fetchIdx);
            exeValid       = doExe;
            mis = 1'b0;
            res = '0;
            if (doExe) begin
                e = prog[idxQ[0]];
                if (nextRand() % 8 == 0)
                    e.kind.isBranch = 1'b0;        // occasional non-branch
                if (nextRand() % 8 == 0)
                    e.isCall = !e.isCall;          // J without link or JR with link
                e.opA = pickOperand();
                if (e.kind.branchCode == `BRANCH_CODE_JR)
                    e.opA = (nextRand() % 4 != 0) ? lastLink : poolPc(3'(nextRand() % 8));
                e.opB = (nextRand() % 2 != 0) ? e.opA : pickOperand();
                exeIn = e;
                res   = modelResolve(e, predQ[0]);
                mis   = predQ[0].target != res.target;
            end
            look      = modelLookup(fetchReq.pc);
            expCredit = mis ? 3'(predQ.size() + int'(doFetch)) : 3'(doExe);
            #4;
            compareCredit(expCredit);

            // advance the model across the coming edge
            trainModel(pendUpd);
            pendUpd = res;
            if (doFetch && !mis && look.hit) begin
                if (look.kind == predictPkg::call) begin
                    mRas[mRasPtr] = fetchReq.pc + 32'd8;
                    mRasPtr       = mRasPtr + 1'b1;
                    if (mRasCnt < `RAS_DEPTH)
                        mRasCnt++;
                end else if (look.kind == predictPkg::retn && mRasCnt != 0) begin
                    mRasPtr = mRasPtr - 1'b1;
                    mRasCnt--;
                end
            end
            if (doExe && res.kind == predictPkg::call)
                lastLink = predQ[0].pc + 32'd8;
            expPred       = look;
            expPred.valid = doFetch && !mis;   // wrong-path lookup dropped
            expRedirect   = mis;
            expVector     = res.target;
            credits       = credits - int'(doFetch) + int'(creditReturn);
            if (mis) begin
                predQ.delete();
                idxQ.delete();
            end else begin
                if (doExe) begin
                    void'(predQ.pop_front());
                    void'(idxQ.pop_front());
                end
                if (doFetch) begin
                    predQ.push_back(look);
                    idxQ.push_back(fetchIdx);
                end
            end
        end

        @(posedge clk);
        #1;
        comparePred(expPred);
        compareRedirect(expRedirect, expVector);
        compareHead(1'b0);
        if (credits != `PRED_QUEUE_DEPTH || predQ.size() != 0) begin
            stopOnError("credit count did not return to the queue depth after draining");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

//--- project.f
+incdir+include
design/decodePkg.sv
design/predictPkg.sv
design/creditFifo.sv
design/branchPredictor.sv
design/branchSolve.sv
design/branchUnit.sv
bench/branchUnit_checker.sv
bench/branchUnitTb.sv

//--- run.sh
#!/bin/sh
# build the branch unit regression with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module branchUnitTb -o simBranchUnit
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/simBranchUnit 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
